//--- build.f
+incdir+hw
hw/spi_pkg.sv
hw/spi_bit_counter.sv
hw/spi_transaction_fsm.sv
hw/spi_shifter.sv
hw/spi_register_bank.sv
hw/pll_csr.sv
hw/spi_top.sv
tests/spi_tb.sv

//--- run.sh
#!/bin/sh
# Build the SPI subsystem testbench with Verilator, run it and check the log

verilator --binary --timing --assert -Wno-fatal --top-module spi_tb \
    -f build.f --Mdir obj_dir -o spi_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/spi_sim > sim.log 2>&1
cat sim.log

grep -qx "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tests/spi_tb.sv
// Self-checking testbench for spi_top, runs SPI register transactions against a reference model
`timescale 1ns/1ps

`include "spi_settings.svh"

`default_nettype none

module spi_tb import spi_pkg::*; ();

    localparam int CLOCK_PERIOD      = 8;
    localparam int COUNT_WIDTH       = `SPI_COUNT_WIDTH;
    localparam int TRANSACTION_COUNT = 14;
    localparam int MAX_BYTES         = 6;     // Opcode plus the longest burst
    localparam int MARGIN_NS         = 1000;  // Reset, lock wait and idle gaps
    localparam int TIMEOUT_NS =
        TRANSACTION_COUNT * (MAX_BYTES + 2) * 8 * CLOCK_PERIOD + MARGIN_NS;

    logic                   spi_clock;
    logic                   rst_n;
    logic                   spi_select;
    logic                   spi_mosi;
    logic                   spi_miso;
    logic                   pll_powerdown_n;
    logic                   image_buffer_read_en;
    logic [COUNT_WIDTH-1:0] operand_count;

    // Reference model state
    logic [7:0] model_scratch;
    logic       model_powerdown_n;
    logic       model_read_en;
    int         model_powerup_edge;  // Edge on which powerdown_n last rose

    int         edge_count = 0;
    integer     seed = 32'h4f10c8f1;
    logic [7:0] operand_q[$];
    logic [7:0] got_q[$];
    logic [7:0] exp_q[$];
    logic [7:0] op_q[$];
    event       byte_captured;

    spi_top uut (
        .spi_clock            (spi_clock),
        .rst_n                (rst_n),
        .spi_select           (spi_select),
        .spi_mosi             (spi_mosi),
        .spi_miso             (spi_miso),
        .pll_powerdown_n      (pll_powerdown_n),
        .image_buffer_read_en (image_buffer_read_en),
        .operand_count        (operand_count)
    );

    initial begin
        spi_clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) spi_clock = ~spi_clock;
    end

    always @(posedge spi_clock) edge_count <= edge_count + 1;

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_byte(input logic [7:0] got, input logic [7:0] expected,
                                input string what);
        if (got !== expected) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s got %02h, expected %02h",
                                    $time, what, got, expected));
        end
    endtask

    task automatic compare_csr(input pll_csr_t got, input pll_csr_t expected);
        if (got.raw !== expected.raw) begin
            stop_on_error($sformatf(
                "Mismatch at %0t ns: PLL CSR locked/read_en/powerdown_n got %b%b%b, expected %b%b%b",
                $time, got.fields.locked, got.fields.read_en, got.fields.powerdown_n,
                expected.fields.locked, expected.fields.read_en, expected.fields.powerdown_n));
        end
    endtask

    task automatic compare_count(input logic [COUNT_WIDTH-1:0] got,
                                 input logic [COUNT_WIDTH-1:0] expected);
        if (got !== expected) begin
            stop_on_error($sformatf("Mismatch at %0t ns: operand_count got %0d, expected %0d",
                                    $time, got, expected));
        end
    endtask

    task automatic compare_bit(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s got %b, expected %b",
                                    $time, what, got, expected));
        end
    endtask

    // Value the addressed register shows at the current edge
    function automatic logic [7:0] expected_response(input logic [7:0] opcode);
        pll_csr_t csr;
        csr                    = '0;
        csr.fields.powerdown_n = model_powerdown_n;
        csr.fields.read_en     = model_read_en;
        csr.fields.locked      = model_powerdown_n &&
                                 (edge_count > model_powerup_edge + `PLL_LOCK_CYCLES);
        case (opcode)
            `SPI_OPCODE_CHIP_ID: return `SPI_CHIP_ID_VALUE;
            `SPI_OPCODE_SCRATCH: return model_scratch;
            `SPI_OPCODE_PLL_CSR: return csr.raw;
            default:             return 8'h00;
        endcase
    endfunction

    task automatic apply_write(input logic [7:0] opcode, input logic [7:0] value,
                               input int write_edge);
        pll_csr_t wr;
        wr = value;
        if (opcode == `SPI_OPCODE_SCRATCH) begin
            model_scratch = value;
        end else if (opcode == `SPI_OPCODE_PLL_CSR) begin
            if (wr.fields.powerdown_n && !model_powerdown_n) begin
                model_powerup_edge = write_edge;  // Lock timer starts over
            end
            model_powerdown_n = wr.fields.powerdown_n;
            model_read_en     = wr.fields.read_en && !wr.fields.powerdown_n;
        end
    endtask

    // Starts and ends 1 ns after a rising edge, MSB first
    task automatic shift_bits(input logic [7:0] tx, input int count, output logic [7:0] rx);
        int i;
        rx = 8'h00;
        for (i = 7; i > 7 - count; i--) begin
            spi_mosi = tx[i];
            #(CLOCK_PERIOD - 2);
            rx[i] = spi_miso;  // Just before the sampling edge
            @(posedge spi_clock);
            #1;
        end
    endtask

    task automatic run_transaction(input logic [7:0] opcode);
        logic [7:0]             rx;
        logic [7:0]             expected;
        logic [7:0]             pend_operand;
        logic [COUNT_WIDTH-1:0] expected_count;
        int                     pend_edge;
        bit                     pend_valid;
        int                     n;
        pend_valid   = 1'b0;
        pend_operand = 8'h00;
        pend_edge    = 0;
        @(posedge spi_clock);
        #1;
        spi_select = 1'b0;
        shift_bits(opcode, 8, rx);
        for (n = 0; n < operand_q.size(); n++) begin
            expected = expected_response(opcode);  // Response was loaded on the last edge
            shift_bits(operand_q[n], 8, rx);
            got_q.push_back(rx);
            exp_q.push_back(expected);
            op_q.push_back(opcode);
            -> byte_captured;
            // Previous operand lands after this byte's response was loaded
            if (pend_valid) apply_write(opcode, pend_operand, pend_edge);
            pend_operand = operand_q[n];
            pend_edge    = edge_count + 1;
            pend_valid   = 1'b1;
        end
        expected_count = COUNT_WIDTH'(operand_q.size());
        compare_count(operand_count, expected_count);
        spi_select = 1'b1;
        spi_mosi   = 1'b0;
        if (pend_valid) apply_write(opcode, pend_operand, pend_edge);
    endtask

    // Deselect in the middle of an operand byte
    task automatic abort_transaction(input logic [7:0] opcode, input logic [7:0] partial,
                                     input int bits);
        logic [7:0] rx;
        @(posedge spi_clock);
        #1;
        spi_select = 1'b0;
        shift_bits(opcode, 8, rx);
        shift_bits(partial, bits, rx);
        spi_select = 1'b1;
        spi_mosi   = 1'b0;
    endtask

    task automatic fill_random(input int count);
        logic [31:0] rnd;
        operand_q.delete();
        repeat (count) begin
            rnd = $random(seed);
            operand_q.push_back(rnd[7:0]);
        end
    endtask

    task automatic single_operand(input logic [7:0] value);
        operand_q.delete();
        operand_q.push_back(value);
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge spi_clock);
        #1;
    endtask

    task automatic check_pins();
        compare_bit(pll_powerdown_n, model_powerdown_n, "pll_powerdown_n");
        compare_bit(image_buffer_read_en, model_read_en, "image_buffer_read_en");
    endtask

    initial begin : response_checker
        logic [7:0] got;
        logic [7:0] expected;
        logic [7:0] opcode;
        forever begin
            @(byte_captured);
            while (got_q.size() > 0) begin
                got      = got_q.pop_front();
                expected = exp_q.pop_front();
                opcode   = op_q.pop_front();
                if (opcode == `SPI_OPCODE_PLL_CSR) compare_csr(got, expected);
                else compare_byte(got, expected, "response byte");
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        stop_on_error("Timeout: the tests did not finish within the time limit");
    end

    initial begin : stimulus
        rst_n              = 1'b0;
        spi_select         = 1'b1;
        spi_mosi           = 1'b0;
        model_scratch      = 8'h00;
        model_powerdown_n  = 1'b1;
        model_read_en      = 1'b0;
        model_powerup_edge = 0;
        repeat (16) @(posedge spi_clock);
        #1;
        rst_n              = 1'b1;
        model_powerup_edge = edge_count;

        // Reset values on the pins
        compare_bit(pll_powerdown_n, 1'b1, "pll_powerdown_n after reset");
        compare_bit(image_buffer_read_en, 1'b0, "image_buffer_read_en after reset");
        compare_bit(spi_miso, 1'b0, "spi_miso after reset");

        fill_random(3);
        run_transaction(`SPI_OPCODE_CHIP_ID);

        // Scratch burst, then read back the last byte
        fill_random(5);
        run_transaction(`SPI_OPCODE_SCRATCH);
        single_operand(model_scratch);
        run_transaction(`SPI_OPCODE_SCRATCH);

        // Power down, then move the image buffer to the SPI clock
        single_operand(8'h00);
        run_transaction(`SPI_OPCODE_PLL_CSR);
        single_operand(8'h02);
        run_transaction(`SPI_OPCODE_PLL_CSR);
        single_operand(8'h02);
        run_transaction(`SPI_OPCODE_PLL_CSR);
        wait_cycles(2);
        check_pins();

        // Power up, read before and after lock
        single_operand(8'h01);
        run_transaction(`SPI_OPCODE_PLL_CSR);
        wait_cycles(2);
        check_pins();
        single_operand(8'h01);
        run_transaction(`SPI_OPCODE_PLL_CSR);
        wait_cycles(`PLL_LOCK_CYCLES + 10);
        single_operand(8'h01);
        run_transaction(`SPI_OPCODE_PLL_CSR);

        // Unknown opcode and aborted writes
        fill_random(2);
        run_transaction(8'h5A);
        abort_transaction(`SPI_OPCODE_SCRATCH, 8'hA5, 4);
        abort_transaction(`SPI_OPCODE_PLL_CSR, 8'h00, 5);
        single_operand(model_scratch);
        run_transaction(`SPI_OPCODE_SCRATCH);
        single_operand(8'h01);
        run_transaction(`SPI_OPCODE_PLL_CSR);
        wait_cycles(2);
        check_pins();

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/spi_top.sv
// Top level of the SPI control subsystem, joins the SPI pins to the counter, FSM and registers
`timescale 1ns/1ps

`include "spi_settings.svh"

`default_nettype none

module spi_top import spi_pkg::*; (
    input  logic                        spi_clock,
    input  logic                        rst_n,
    input  logic                        spi_select,    // Active low
    input  logic                        spi_mosi,
    output logic                        spi_miso,
    output logic                        pll_powerdown_n,
    output logic                        image_buffer_read_en,
    output logic [`SPI_COUNT_WIDTH-1:0] operand_count
);

    logic                        byte_done;
    logic [`SPI_COUNT_WIDTH-1:0] byte_count;
    logic [7:0]                  rx_byte;
    logic [7:0]                  opcode;
    logic [7:0]                  operand;
    logic                        operand_wr_en;
    logic                        load_response;
    logic [7:0]                  response;
    pll_csr_t                    csr;

    // Opcode byte excluded
    assign operand_count = (byte_count == '0) ? '0 : byte_count - 1'b1;

    spi_bit_counter spi_bit_counter (
        .spi_clock  (spi_clock),
        .rst_n      (rst_n),
        .spi_select (spi_select),
        .byte_done  (byte_done),
        .byte_count (byte_count)
    );

    spi_transaction_fsm spi_transaction_fsm (
        .spi_clock     (spi_clock),
        .rst_n         (rst_n),
        .spi_select    (spi_select),
        .byte_done     (byte_done),
        .rx_byte       (rx_byte),
        .opcode        (opcode),
        .operand       (operand),
        .operand_wr_en (operand_wr_en),
        .operand_rd_en (),             // No read-side consumer in this subsystem
        .load_response (load_response),
        .phase         ()
    );

    spi_shifter spi_shifter (
        .spi_clock     (spi_clock),
        .rst_n         (rst_n),
        .spi_select    (spi_select),
        .spi_mosi      (spi_mosi),
        .load_response (load_response),
        .response      (response),
        .spi_miso      (spi_miso),
        .rx_byte       (rx_byte)
    );

    spi_register_bank spi_register_bank (
        .spi_clock     (spi_clock),
        .rst_n         (rst_n),
        .opcode        (opcode),
        .operand       (operand),
        .operand_wr_en (operand_wr_en),
        .csr           (csr),
        .response      (response)
    );

    pll_csr pll_csr (
        .spi_clock            (spi_clock),
        .rst_n                (rst_n),
        .opcode               (opcode),
        .operand              (operand),
        .operand_wr_en        (operand_wr_en),
        .csr                  (csr),
        .pll_powerdown_n      (pll_powerdown_n),
        .image_buffer_read_en (image_buffer_read_en)  // Selects SPI clock for buffer reads
    );

endmodule

`default_nettype wire

//--- hw/pll_csr.sv
// PLL control and status register with a lock-delay model, written over SPI at its opcode
`timescale 1ns/1ps

`include "spi_settings.svh"

`default_nettype none

module pll_csr import spi_pkg::*; (
    input  logic       spi_clock,
    input  logic       rst_n,
    input  logic [7:0] opcode,
    input  logic [7:0] operand,
    input  logic       operand_wr_en,
    output pll_csr_t   csr,
    output logic       pll_powerdown_n,
    output logic       image_buffer_read_en
);

    localparam int LOCK_WIDTH = $clog2(`PLL_LOCK_CYCLES + 1);
    localparam logic [LOCK_WIDTH-1:0] LOCK_DONE = LOCK_WIDTH'(`PLL_LOCK_CYCLES);

    pll_csr_t              wr_view;  // Incoming operand by field
    logic                  csr_write;
    logic [LOCK_WIDTH-1:0] lock_count;
    logic                  locked;

    assign wr_view   = operand;
    assign csr_write = operand_wr_en && (opcode == `SPI_OPCODE_PLL_CSR);
    assign locked    = (lock_count == LOCK_DONE);

    always_ff @(posedge spi_clock or negedge rst_n) begin
        if (!rst_n) begin
            pll_powerdown_n      <= 1'b1;  // PLL runs out of reset
            image_buffer_read_en <= 1'b0;
        end else if (csr_write) begin
            pll_powerdown_n <= wr_view.fields.powerdown_n;
            // Buffer may only move to the SPI clock while the PLL is off
            image_buffer_read_en <= wr_view.fields.read_en && !wr_view.fields.powerdown_n;
        end
    end

    // Lock timer
    // Cleared by the same write that powers down, so lock never outlives power
    always_ff @(posedge spi_clock or negedge rst_n) begin
        if (!rst_n) begin
            lock_count <= '0;
        end else if (csr_write && !wr_view.fields.powerdown_n) begin
            lock_count <= '0;
        end else if (pll_powerdown_n && !locked) begin
            lock_count <= lock_count + 1'b1;
        end
    end

    always_comb begin
        csr                    = '0;
        csr.fields.locked      = locked;
        csr.fields.read_en     = image_buffer_read_en;
        csr.fields.powerdown_n = pll_powerdown_n;
    end

    assert property (@(posedge spi_clock) disable iff (!rst_n)
        image_buffer_read_en |-> !pll_powerdown_n);

    assert property (@(posedge spi_clock) disable iff (!rst_n)
        csr.fields.locked |-> pll_powerdown_n);

endmodule

`default_nettype wire

//--- hw/spi_register_bank.sv
// Chip ID and scratch registers, plus the response mux for the addressed register
`timescale 1ns/1ps

`include "spi_settings.svh"

`default_nettype none

module spi_register_bank import spi_pkg::*; (
    input  logic       spi_clock,
    input  logic       rst_n,
    input  logic [7:0] opcode,
    input  logic [7:0] operand,
    input  logic       operand_wr_en,
    input  pll_csr_t   csr,           // Status from the PLL block
    output logic [7:0] response
);

    logic [7:0] scratch;
    logic       scratch_write;

    assign scratch_write = operand_wr_en && (opcode == `SPI_OPCODE_SCRATCH);

    // Holds the last operand written, earlier bytes of a burst are overwritten
    always_ff @(posedge spi_clock or negedge rst_n) begin
        if (!rst_n) begin
            scratch <= 8'h00;
        end else if (scratch_write) begin
            scratch <= operand;
        end
    end

    // Response for the addressed register
    always_comb begin
        case (opcode)
            `SPI_OPCODE_CHIP_ID: response = `SPI_CHIP_ID_VALUE;
            `SPI_OPCODE_SCRATCH: response = scratch;
            `SPI_OPCODE_PLL_CSR: response = csr.raw;
            default:             response = 8'h00;  // Unknown opcodes read as zero
        endcase
    end

endmodule

`default_nettype wire

//--- hw/spi_shifter.sv
// SPI data shifter that assembles received bytes and shifts the response out MSB first
`timescale 1ns/1ps

`default_nettype none

module spi_shifter (
    input  logic       spi_clock,
    input  logic       rst_n,
    input  logic       spi_select,
    input  logic       spi_mosi,
    input  logic       load_response,
    input  logic [7:0] response,
    output logic       spi_miso,
    output logic [7:0] rx_byte
);

    logic [6:0] rx_shift;  // First seven bits of the byte in flight
    logic [7:0] tx_shift;

    // Valid on byte_done while the last bit still sits on the pin
    assign rx_byte = {rx_shift, spi_mosi};

    assign spi_miso = tx_shift[7];

    always_ff @(posedge spi_clock or negedge rst_n) begin
        if (!rst_n) begin
            rx_shift <= 7'h00;
        end else if (!spi_select) begin
            rx_shift <= {rx_shift[5:0], spi_mosi};
        end
    end

    always_ff @(posedge spi_clock or negedge rst_n) begin
        if (!rst_n) begin
            tx_shift <= 8'h00;
        end else if (spi_select) begin
            tx_shift <= 8'h00;  // Quiet line between transactions
        end else if (load_response) begin
            tx_shift <= response;  // Bit 7 visible before the next edge
        end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

//--- hw/spi_transaction_fsm.sv
// Transaction FSM that latches the opcode and issues operand strobes and response loads
`timescale 1ns/1ps

`default_nettype none

module spi_transaction_fsm import spi_pkg::*; (
    input  logic       spi_clock,
    input  logic       rst_n,
    input  logic       spi_select,
    input  logic       byte_done,
    input  logic [7:0] rx_byte,
    output logic [7:0] opcode,
    output logic [7:0] operand,
    output logic       operand_wr_en,
    output logic       operand_rd_en,
    output logic       load_response,
    output spi_phase_t phase
);

    spi_phase_t phase_next;
    logic [7:0] opcode_q;
    logic       opcode_done;
    logic       operand_done;

    assign opcode_done  = byte_done && (phase == phase_opcode);
    assign operand_done = byte_done && (phase == phase_operand);

    // The new opcode is forwarded on its own last edge so the first response
    // byte is decoded from it and not from the previous transaction
    assign opcode = opcode_done ? rx_byte : opcode_q;

    assign load_response = byte_done && (phase != phase_idle);  // Next byte goes out at once

    always_comb begin
        phase_next = phase;
        if (spi_select) begin
            phase_next = phase_idle;
        end else begin
            case (phase)
                phase_idle:    phase_next = phase_opcode;
                phase_opcode:  if (byte_done) phase_next = phase_operand;
                phase_operand: phase_next = phase_operand;  // Until deselect
                default:       phase_next = phase_idle;
            endcase
        end
    end

    always_ff @(posedge spi_clock or negedge rst_n) begin
        if (!rst_n) begin
            phase         <= phase_idle;
            opcode_q      <= 8'h00;
            operand_wr_en <= 1'b0;
            operand_rd_en <= 1'b0;
        end else begin
            phase         <= phase_next;
            operand_wr_en <= operand_done;  // Write lands one edge after the last bit
            operand_rd_en <= operand_done;
            if (opcode_done) begin
                opcode_q <= rx_byte;
            end
        end
    end

    always_ff @(posedge spi_clock or negedge rst_n) begin
        if (!rst_n) begin
            operand <= 8'h00;
        end else if (operand_done) begin
            operand <= rx_byte;
        end
    end

    // Strobe must fall inside the operand phase even when select rises after the last byte
    assert property (@(posedge spi_clock) disable iff (!rst_n)
        operand_wr_en |-> (phase == phase_operand));

endmodule

`default_nettype wire

//--- hw/spi_bit_counter.sv
// Bit and byte counter for one SPI transaction, flags the last bit of every byte
`timescale 1ns/1ps

`include "spi_settings.svh"

`default_nettype none

module spi_bit_counter (
    input  logic                        spi_clock,
    input  logic                        rst_n,
    input  logic                        spi_select,   // Active low
    output logic                        byte_done,
    output logic [`SPI_COUNT_WIDTH-1:0] byte_count
);

    logic [2:0] bit_index;  // Bit about to be sampled, 0 is the MSB

    // High on the edge that samples bit 0 of a byte
    assign byte_done = !spi_select && (bit_index == 3'd7);

    always_ff @(posedge spi_clock or negedge rst_n) begin
        if (!rst_n) begin
            bit_index <= 3'd0;
        end else if (spi_select) begin
            bit_index <= 3'd0;  // Deselect drops any partial byte
        end else begin
            bit_index <= bit_index + 3'd1;  // Wraps to 0 after bit 0
        end
    end

    // Completed bytes in this transaction
    // The opcode byte is index 0
    always_ff @(posedge spi_clock or negedge rst_n) begin
        if (!rst_n) begin
            byte_count <= '0;
        end else if (spi_select) begin
            byte_count <= '0;
        end else if (byte_done && (byte_count != '1)) begin
            byte_count <= byte_count + 1'b1;  // Sticks at all ones
        end
    end

endmodule

`default_nettype wire

//--- hw/spi_pkg.sv
// Shared types for the SPI subsystem, imported by the FSM, register blocks and testbench
`default_nettype none

package spi_pkg;

    // Transaction phase, first byte is the opcode and the rest are operands
    typedef enum logic [1:0] {
        phase_idle    = 2'd0,
        phase_opcode  = 2'd1,
        phase_operand = 2'd2
    } spi_phase_t;

    // PLL control and status byte, seen either whole or by field
    typedef union packed {
        logic [7:0] raw;            // As shifted over SPI
        struct packed {
            logic [4:0] reserved;   // Reads as zero
            logic       locked;     // Status only
            logic       read_en;    // Image buffer read select
            logic       powerdown_n;
        } fields;
    } pll_csr_t;

endpackage

`default_nettype wire

//--- hw/spi_settings.svh
// Opcodes, chip ID and PLL lock timing shared by the SPI subsystem, pulled in with `include
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// Register opcodes, sent as the first byte of each transaction
`define SPI_OPCODE_CHIP_ID 8'hDB
`define SPI_OPCODE_SCRATCH 8'h30
`define SPI_OPCODE_PLL_CSR 8'h40

// Fixed chip identification byte
`define SPI_CHIP_ID_VALUE 8'h81

// Width of the per-transaction byte counter
`define SPI_COUNT_WIDTH 16

// PLL lock model
// spi_clock edges from power-up until lock is reported
`define PLL_LOCK_CYCLES 20

`endif
